// File: rtl/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// ==========================================================
// Widths of the fetch datapath
// ==========================================================

// Byte address of an instruction word
`define FETCH_ADDR_W 16
`define FETCH_INSTR_W 32

// Queue geometry and the occupancy counter that covers it
`define FETCH_DEPTH 16
`define FETCH_CNT_W 5

// Fetch holds off once occupancy passes the depth minus this margin
`define FETCH_AF_MARGIN 5

// Configuration register map
`define FETCH_REG_BOOT 0
`define FETCH_REG_CTRL 1

// ==========================================================
// Instruction field layout
// ==========================================================
`define OPC_LSB 29
`define OPC_W 3
`define RD_LSB 23
`define RS_LSB 18
`define REG_W 5
`define IMM_W 16

`endif

// File: rtl/fetch_pkg.sv
`default_nettype none

`include "fetch_consts.svh"

// Types seen on the fetch side of the buffer
package fetch_pkg;

	// Byte address, always word aligned
	typedef logic [`FETCH_ADDR_W-1:0] addr_t;

	// Raw instruction word as returned by memory
	typedef logic [`FETCH_INSTR_W-1:0] instr_t;

	// Queue occupancy, wide enough to hold the full depth
	typedef logic [`FETCH_CNT_W-1:0] fifo_cnt_t;

	// Only two configuration registers exist
	typedef logic [0:0] reg_addr_t;

	// One queue slot keeps the word together with where it came from
	typedef struct packed {
		addr_t pc;
		instr_t instr;
	} fetch_entry_t;

	// Configuration state handed to the sequencer
	typedef struct packed {
		logic run;
		addr_t boot_pc;
	} fetch_cfg_t;

endpackage

`default_nettype wire

// File: rtl/decode_pkg.sv
`default_nettype none

`include "fetch_consts.svh"

// Types seen by the decode stage
package decode_pkg;

	// Instruction class follows the opcode directly for the first five codes
	// Everything from opcode 5 upward folds into CLS_OTHER
	typedef enum logic [`OPC_W-1:0] {
		CLS_ALU = 3'd0,
		CLS_ALU_IMM = 3'd1,
		CLS_LOAD = 3'd2,
		CLS_STORE = 3'd3,
		CLS_BRANCH = 3'd4,
		CLS_OTHER = 3'd5
	} instr_class_e;

	// Architectural register index
	typedef logic [`REG_W-1:0] reg_idx_t;

	// Record presented to decode for the head of the queue
	// The immediate is already sign extended to the full word
	typedef struct packed {
		fetch_pkg::addr_t pc;
		fetch_pkg::instr_t instr;
		instr_class_e cls;
		reg_idx_t rd;
		reg_idx_t rs;
		logic [`FETCH_INSTR_W-1:0] imm;
	} decoded_t;

endpackage

`default_nettype wire

// File: rtl/fetch_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

// Configuration registers for the fetch unit
// Writing the boot address also requests a restart from that address
module fetch_regs (
	input wire clk,
	input wire rst,
	input wire reg_wr,
	input wire fetch_pkg::reg_addr_t reg_addr,
	input wire fetch_pkg::addr_t reg_wdata,
	output fetch_pkg::fetch_cfg_t cfg,
	output logic restart
);

	localparam fetch_pkg::reg_addr_t REG_BOOT = fetch_pkg::reg_addr_t'(`FETCH_REG_BOOT);
	localparam fetch_pkg::reg_addr_t REG_CTRL = fetch_pkg::reg_addr_t'(`FETCH_REG_CTRL);

	// Restart is registered so it lines up with the new boot_pc value
	always_ff @(posedge clk) begin
		if (rst) begin
			cfg <= '0;
			restart <= 1'b0;
		end else begin
			// Pulse lasts a single cycle unless another boot write follows
			restart <= 1'b0;
			if (reg_wr) begin
				case (reg_addr)
					REG_BOOT: begin
						cfg.boot_pc <= reg_wdata;
						restart <= 1'b1;
					end
					REG_CTRL: begin
						// Only bit 0 of the control word is defined
						cfg.run <= reg_wdata[0];
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/fetch_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

// Circular buffer with first-word-fall-through reads
// The head entry is always visible on dout while v is high
module fetch_fifo #(
	parameter int WID = 48,
	parameter int DEP = 16
) (
	input wire clk,
	input wire rst,
	input wire clear,
	input wire wr,
	input wire [WID-1:0] di,
	input wire rd,
	output logic [WID-1:0] dout,
	output fetch_pkg::fifo_cnt_t cnt,
	output logic almost_full,
	output logic full,
	output logic empty,
	output logic v
);

	localparam int PTR_W = (DEP > 1) ? $clog2(DEP) : 1;
	localparam fetch_pkg::fifo_cnt_t DEP_CNT = fetch_pkg::fifo_cnt_t'(DEP);
	localparam fetch_pkg::fifo_cnt_t AF_LIMIT =
		fetch_pkg::fifo_cnt_t'(DEP - `FETCH_AF_MARGIN);

	logic [WID-1:0] mem [DEP];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic wr_en;
	logic rd_en;

	// Pointers wrap explicitly so depths that are not a power of two work
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEP - 1)) begin
			ptr_next = '0;
		end else begin
			ptr_next = p + 1'b1;
		end
	endfunction

	// A read from an empty queue is dropped
	// A write to a full queue only goes in when a read frees a slot
	always_comb begin
		rd_en = rd & ~empty;
		wr_en = wr & (~full | rd_en);
	end

	// ==========================================================
	// Pointers and occupancy
	// ==========================================================
	always_ff @(posedge clk) begin
		if (rst || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (rd_en) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			// Simultaneous read and write leaves the count unchanged
			case ({wr_en, rd_en})
				2'b10: cnt <= cnt + 1'b1;
				2'b01: cnt <= cnt - 1'b1;
				default: cnt <= cnt;
			endcase
		end
	end

	// Entry storage, filled at the write pointer
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= di;
		end
	end

	// All flags come straight from the occupancy
	always_comb begin
		dout = mem[rd_ptr];
		almost_full = cnt > AF_LIMIT;
		full = cnt == DEP_CNT;
		empty = cnt == '0;
		v = cnt != '0;
	end

endmodule

`default_nettype wire

// File: rtl/fetch_seq.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

// Program counter sequencer
// Issues one word request per cycle while allowed and pairs each response
// with the address that produced it
module fetch_seq (
	input wire clk,
	input wire rst,
	input wire fetch_pkg::fetch_cfg_t cfg,
	input wire restart,
	input wire redirect,
	input wire fetch_pkg::addr_t redirect_pc,
	input wire almost_full,
	input wire fetch_pkg::instr_t imem_data,
	output logic imem_req,
	output fetch_pkg::addr_t imem_addr,
	output logic flush,
	output logic q_wr,
	output fetch_pkg::fetch_entry_t q_entry
);

	// One instruction word per request
	localparam fetch_pkg::addr_t PC_STEP = fetch_pkg::addr_t'(`FETCH_INSTR_W / 8);

	fetch_pkg::addr_t pc_q;
	logic pend_q;
	fetch_pkg::addr_t pend_pc_q;

	// ==========================================================
	// Request side
	// ==========================================================

	// Either a new boot address or a taken branch throws away queued work
	always_comb begin
		flush = restart | redirect;
		imem_req = cfg.run & ~flush & ~almost_full;
		imem_addr = pc_q;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= '0;
			pend_q <= 1'b0;
		end else if (flush) begin
			// Redirect wins over a restart landing in the same cycle
			pc_q <= redirect ? redirect_pc : cfg.boot_pc;
			// The request in flight belongs to the old stream
			pend_q <= 1'b0;
		end else begin
			if (imem_req) begin
				pc_q <= pc_q + PC_STEP;
			end
			pend_q <= imem_req;
		end
	end

	// Address of the outstanding request
	always_ff @(posedge clk) begin
		if (imem_req) begin
			pend_pc_q <= pc_q;
		end
	end

	// ==========================================================
	// Response side
	// ==========================================================

	// Memory data is valid the cycle after the request
	// A response that arrives together with a flush is dropped
	always_comb begin
		q_wr = pend_q & ~flush;
		q_entry.pc = pend_pc_q;
		q_entry.instr = imem_data;
	end

endmodule

`default_nettype wire

// File: rtl/predecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

// Combinational predecoder on the queue head
// Decode sees the record in the same cycle the entry reaches the head
module predecode (
	input wire fetch_pkg::fetch_entry_t head,
	input wire head_v,
	input wire consume,
	output logic q_rd,
	output decode_pkg::decoded_t out,
	output logic out_valid
);

	logic [`OPC_W-1:0] opc;

	always_comb begin
		opc = head.instr[`OPC_LSB +: `OPC_W];

		out.pc = head.pc;
		out.instr = head.instr;

		// Opcodes 5 to 7 have no dedicated class yet
		case (opc)
			3'd0: out.cls = decode_pkg::CLS_ALU;
			3'd1: out.cls = decode_pkg::CLS_ALU_IMM;
			3'd2: out.cls = decode_pkg::CLS_LOAD;
			3'd3: out.cls = decode_pkg::CLS_STORE;
			3'd4: out.cls = decode_pkg::CLS_BRANCH;
			default: out.cls = decode_pkg::CLS_OTHER;
		endcase

		// Register fields sit at fixed positions for every class
		out.rd = head.instr[`RD_LSB +: `REG_W];
		out.rs = head.instr[`RS_LSB +: `REG_W];

		// Low half of the word is the immediate, extended from its top bit
		out.imm = {{(`FETCH_INSTR_W - `IMM_W){head.instr[`IMM_W-1]}},
			head.instr[`IMM_W-1:0]};

		out_valid = head_v;

		// The queue itself ignores a pop while empty
		q_rd = consume;
	end

endmodule

`default_nettype wire

// File: rtl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

// Instruction fetch buffer
// Sequencer feeds the queue from instruction memory and the predecoder
// drains it toward decode
module fetch_unit (
	input wire clk,
	input wire rst,
	input wire reg_wr,
	input wire fetch_pkg::reg_addr_t reg_addr,
	input wire fetch_pkg::addr_t reg_wdata,
	input wire redirect,
	input wire fetch_pkg::addr_t redirect_pc,
	input wire fetch_pkg::instr_t imem_data,
	input wire consume,
	output logic imem_req,
	output fetch_pkg::addr_t imem_addr,
	output decode_pkg::decoded_t out,
	output logic out_valid
);

	fetch_pkg::fetch_cfg_t cfg;
	logic restart;
	logic flush;
	logic almost_full;
	logic q_wr;
	logic q_rd;
	fetch_pkg::fetch_entry_t q_entry;
	fetch_pkg::fetch_entry_t head;
	logic head_v;

	fetch_regs i_fetch_regs (
		.clk(clk),
		.rst(rst),
		.reg_wr(reg_wr),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.cfg(cfg),
		.restart(restart)
	);

	fetch_seq i_fetch_seq (
		.clk(clk),
		.rst(rst),
		.cfg(cfg),
		.restart(restart),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.almost_full(almost_full),
		.imem_data(imem_data),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.flush(flush),
		.q_wr(q_wr),
		.q_entry(q_entry)
	);

	// Count, full and empty are left open since back-pressure uses almost_full
	// and the predecoder works from the valid level
	fetch_fifo #(
		.WID($bits(fetch_pkg::fetch_entry_t)),
		.DEP(`FETCH_DEPTH)
	) i_fetch_fifo (
		.clk(clk),
		.rst(rst),
		.clear(flush),
		.wr(q_wr),
		.di(q_entry),
		.rd(q_rd),
		.dout(head),
		.cnt(),
		.almost_full(almost_full),
		.full(),
		.empty(),
		.v(head_v)
	);

	predecode i_predecode (
		.head(head),
		.head_v(head_v),
		.consume(consume),
		.q_rd(q_rd),
		.out(out),
		.out_valid(out_valid)
	);

endmodule

`default_nettype wire

// File: tests/tb_fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_unit;

	// ==========================================================
	// Constants and stimulus table layout
	// ==========================================================
	localparam int MEM_WORDS = 256;
	localparam int NUM_ROWS = 10;
	localparam int WAIT_LIMIT = 50;
	localparam int MIN_CONSUMED = 60;

	localparam logic [1:0] ACT_RUN = 2'd0;
	localparam logic [1:0] ACT_BOOT = 2'd1;
	localparam logic [1:0] ACT_CTRL = 2'd2;
	localparam logic [1:0] ACT_REDIRECT = 2'd3;

	localparam logic [1:0] CONS_NEVER = 2'd0;
	localparam logic [1:0] CONS_ALWAYS = 2'd1;
	localparam logic [1:0] CONS_ALT = 2'd2;

	// One row is an action, its operand and how the cycles after it are run
	typedef struct packed {
		logic [1:0] act;
		fetch_pkg::addr_t operand;
		logic [7:0] cycles;
		logic [1:0] pattern;
		logic wait_v;
		logic end_chk;
		logic end_valid;
		logic end_req;
	} row_t;

	logic clk;
	logic rst;
	logic reg_wr;
	fetch_pkg::reg_addr_t reg_addr;
	fetch_pkg::addr_t reg_wdata;
	logic redirect;
	fetch_pkg::addr_t redirect_pc;
	fetch_pkg::instr_t imem_data;
	logic consume;
	logic imem_req;
	fetch_pkg::addr_t imem_addr;
	decode_pkg::decoded_t dut_out;
	logic out_valid;

	fetch_pkg::instr_t mem [MEM_WORDS];
	row_t table_rows [NUM_ROWS];
	integer seed;
	fetch_pkg::addr_t exp_pc;
	int n_consumed;

	// Copies of the outputs taken 1 ns after the edge, before inputs move
	logic smp_valid;
	logic smp_req;
	fetch_pkg::addr_t smp_addr;
	decode_pkg::decoded_t smp_out;

	// Request seen in the middle of the cycle, answered after the next edge
	logic mem_req_s;
	fetch_pkg::addr_t mem_addr_s;

	fetch_unit i_fetch_unit (
		.clk(clk),
		.rst(rst),
		.reg_wr(reg_wr),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.imem_data(imem_data),
		.consume(consume),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.out(dut_out),
		.out_valid(out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ==========================================================
	// Instruction memory model
	// ==========================================================
	function automatic int mem_index(input fetch_pkg::addr_t a);
		return int'(a >> 2) % MEM_WORDS;
	endfunction

	always @(negedge clk) begin
		mem_req_s = imem_req;
		mem_addr_s = imem_addr;
	end

	// The word shows up one cycle after its request, like the real memory
	always @(posedge clk) begin
		#2;
		if (mem_req_s === 1'b1) begin
			imem_data = mem[mem_index(mem_addr_s)];
		end
	end

	// ==========================================================
	// Reference model and checks
	// ==========================================================

	// Builds the record decode should see for the word at pc
	function automatic decode_pkg::decoded_t expected_record(input fetch_pkg::addr_t pc);
		fetch_pkg::instr_t w;
		decode_pkg::decoded_t r;
		w = mem[mem_index(pc)];
		r.pc = pc;
		r.instr = w;
		case (w[31:29])
			3'd0: r.cls = decode_pkg::CLS_ALU;
			3'd1: r.cls = decode_pkg::CLS_ALU_IMM;
			3'd2: r.cls = decode_pkg::CLS_LOAD;
			3'd3: r.cls = decode_pkg::CLS_STORE;
			3'd4: r.cls = decode_pkg::CLS_BRANCH;
			default: r.cls = decode_pkg::CLS_OTHER;
		endcase
		r.rd = w[27:23];
		r.rs = w[22:18];
		r.imm = {{16{w[15]}}, w[15:0]};
		return r;
	endfunction

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected)
			stop_on_error($sformatf("mismatch at %0t: %s expected %b actual %b",
				$time, name, expected, actual));
	endtask

	task automatic check_addr(input string name, input fetch_pkg::addr_t actual,
		input fetch_pkg::addr_t expected);
		if (actual !== expected)
			stop_on_error($sformatf("mismatch at %0t: %s expected %h actual %h",
				$time, name, expected, actual));
	endtask

	task automatic check_decoded(input string name, input decode_pkg::decoded_t actual,
		input decode_pkg::decoded_t expected);
		if (actual !== expected)
			stop_on_error($sformatf("mismatch at %0t: %s expected %h actual %h",
				$time, name, expected, actual));
	endtask

	// ==========================================================
	// Cycle driving
	// ==========================================================

	// Samples the outputs, checks the head about to be popped, then drives consume
	task automatic run_cycle(input logic want_consume);
		@(posedge clk);
		#1;
		smp_valid = out_valid;
		smp_req = imem_req;
		smp_addr = imem_addr;
		smp_out = dut_out;
		if (want_consume && smp_valid) begin
			check_decoded("out", smp_out, expected_record(exp_pc));
			exp_pc = exp_pc + 16'd4;
			n_consumed = n_consumed + 1;
		end
		#1;
		consume = want_consume;
		reg_wr = 1'b0;
		redirect = 1'b0;
	endtask

	// Holds one register write or redirect for a single cycle with no pop
	task automatic apply_action(input row_t row);
		@(posedge clk);
		#2;
		consume = 1'b0;
		case (row.act)
			ACT_BOOT: begin
				reg_wr = 1'b1;
				reg_addr = 1'b0;
				reg_wdata = row.operand;
				exp_pc = row.operand;
			end
			ACT_CTRL: begin
				reg_wr = 1'b1;
				reg_addr = 1'b1;
				reg_wdata = row.operand;
			end
			ACT_REDIRECT: begin
				redirect = 1'b1;
				redirect_pc = row.operand;
				exp_pc = row.operand;
			end
			default: begin
				reg_wr = 1'b0;
			end
		endcase
	endtask

	// Steps without popping until the first entry of the new stream shows up
	task automatic wait_valid();
		int n;
		n = 0;
		run_cycle(1'b0);
		while (!smp_valid) begin
			n = n + 1;
			if (n > WAIT_LIMIT)
				stop_on_error("timed out waiting for out_valid after a restart");
			run_cycle(1'b0);
		end
		check_addr("out.pc", smp_out.pc, exp_pc);
	endtask

	// Global limit in case a loop above stops making progress
	initial begin
		#(40 * 3000);
		stop_on_error("watchdog expired before the stimulus table finished");
	end

	initial begin
		fetch_pkg::addr_t held;
		logic want;
		seed = 32'hb47fb38e;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = $random(seed);
		end
		rst = 1'b1;
		reg_wr = 1'b0;
		reg_addr = 1'b0;
		reg_wdata = '0;
		redirect = 1'b0;
		redirect_pc = '0;
		imem_data = '0;
		consume = 1'b0;
		exp_pc = '0;
		n_consumed = 0;
		mem_req_s = 1'b0;
		mem_addr_s = '0;

		// Idle, boot setup, run, back-pressure, redirects, restart and drain
		table_rows[0] = '{ACT_RUN, 16'h0000, 8'd5, CONS_NEVER, 1'b0, 1'b1, 1'b0, 1'b0};
		table_rows[1] = '{ACT_BOOT, 16'h0100, 8'd3, CONS_NEVER, 1'b0, 1'b1, 1'b0, 1'b0};
		table_rows[2] = '{ACT_CTRL, 16'h0001, 8'd30, CONS_ALWAYS, 1'b1, 1'b0, 1'b0, 1'b0};
		table_rows[3] = '{ACT_RUN, 16'h0000, 8'd30, CONS_ALT, 1'b0, 1'b0, 1'b0, 1'b0};
		table_rows[4] = '{ACT_RUN, 16'h0000, 8'd40, CONS_NEVER, 1'b0, 1'b1, 1'b1, 1'b0};
		table_rows[5] = '{ACT_RUN, 16'h0000, 8'd30, CONS_ALWAYS, 1'b0, 1'b0, 1'b0, 1'b0};
		table_rows[6] = '{ACT_REDIRECT, 16'h0800, 8'd20, CONS_ALT, 1'b1, 1'b0, 1'b0, 1'b0};
		table_rows[7] = '{ACT_BOOT, 16'h0200, 8'd20, CONS_ALWAYS, 1'b1, 1'b0, 1'b0, 1'b0};
		table_rows[8] = '{ACT_REDIRECT, 16'hffe0, 8'd20, CONS_ALT, 1'b1, 1'b0, 1'b0, 1'b0};
		table_rows[9] = '{ACT_CTRL, 16'h0000, 8'd30, CONS_ALWAYS, 1'b0, 1'b1, 1'b0, 1'b0};

		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;

		for (int r = 0; r < NUM_ROWS; r++) begin
			if (table_rows[r].act != ACT_RUN) begin
				apply_action(table_rows[r]);
				// The restart or flush lands in this cycle and must not be popped
				run_cycle(1'b0);
			end
			if (table_rows[r].wait_v) begin
				wait_valid();
			end
			for (int c = 0; c < int'(table_rows[r].cycles); c++) begin
				want = (table_rows[r].pattern == CONS_ALWAYS) ||
					((table_rows[r].pattern == CONS_ALT) && c[0]);
				run_cycle(want);
			end
			if (table_rows[r].end_chk) begin
				check_bit("out_valid", smp_valid, table_rows[r].end_valid);
				check_bit("imem_req", smp_req, table_rows[r].end_req);
				// With fetch stalled, entries held are the pcs between head and next fetch
				if (table_rows[r].end_valid && !table_rows[r].end_req) begin
					held = (smp_addr - exp_pc) >> 2;
					if (held > 16'd13 || held == 16'd0)
						stop_on_error($sformatf("queue held %0d entries under back-pressure",
							held));
				end
			end
		end

		if (n_consumed < MIN_CONSUMED) begin
			stop_on_error($sformatf("only %0d entries were consumed", n_consumed));
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/decode_pkg.sv
rtl/fetch_regs.sv
rtl/fetch_fifo.sv
rtl/fetch_seq.sv
rtl/predecode.sv
rtl/fetch_unit.sv
tests/tb_fetch_unit.sv

// File: Makefile
# Verilator build and run of the fetch buffer testbench

VERILATOR ?= verilator
TOP ?= tb_fetch_unit
BUILD_DIR ?= obj_dir
FILELIST ?= all.f
VFLAGS ?= --binary --timing
SIM ?= $(BUILD_DIR)/V$(TOP)

SRCS := $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# A failing check ends in $fatal, which makes the binary exit nonzero
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
